// ==== hdl/ctrlPkg.sv ====
package ctrlPkg;

    // opcode and funct field width
    localparam int FieldW = 6;

    // step counter width
    localparam int StepW = 5;

    // R-type opcode and the supported funct codes
    localparam logic [FieldW-1:0] OpRType     = 6'd0;
    localparam logic [FieldW-1:0] FunctAdd    = 6'd32;
    localparam logic [FieldW-1:0] FunctSub    = 6'd34;
    localparam logic [FieldW-1:0] FunctAnd    = 6'd36;
    localparam logic [FieldW-1:0] FunctSlt    = 6'd42;
    localparam logic [FieldW-1:0] FunctJr     = 6'd8;
    localparam logic [FieldW-1:0] FunctRte    = 6'd19;
    localparam logic [FieldW-1:0] FunctBreak  = 6'd13;

    // phase lengths outside fetch
    localparam int PcUpdateSteps = 1;
    localparam int DecodeSteps   = 3;
    localparam int ExecStepsFull = 2;
    localparam int ExecStepsRte  = 1;

    typedef enum logic [2:0] {
        phReset,
        phFetch,
        phPcUpdate,
        phDecode,
        phExecute
    } Phase;

    typedef enum logic [2:0] {
        opAdd,
        opSub,
        opAnd,
        opSlt,
        opJumpReg,
        opExcReturn,
        opBreak,
        opUnsupported
    } OpKind;

    typedef enum logic [1:0] {
        srcAPc   = 2'd0,
        srcARegA = 2'd2
    } AluSrcA;

    typedef enum logic [1:0] {
        srcBRegB = 2'd0,
        srcBFour = 2'd1
    } AluSrcB;

    typedef enum logic [2:0] {
        aluPass = 3'd0,
        aluAdd  = 3'd1,
        aluSub  = 3'd2,
        aluAnd  = 3'd3,
        aluSlt  = 3'd7
    } AluOp;

    // JR and RTE both take the PC from the register path
    typedef enum logic [2:0] {
        pcFromAlu = 3'd0,
        pcFromReg = 3'd5
    } PcSrc;

    typedef enum logic [1:0] {
        dstNone    = 2'd0,
        dstDefault = 2'd1,
        dstRd      = 2'd3
    } RegDstSel;

    typedef enum logic [3:0] {
        wdNone    = 4'd0,
        wdAluWord = 4'd5,
        wdSltBit  = 4'd9,
        wdReset   = 4'd10
    } WriteDataSel;

    typedef struct packed {
        logic        pcWrite;
        logic        memRead;
        logic        irWrite;
        logic        regWrite;
        logic        aluOutWrite;
        AluSrcA      aluSrcA;
        AluSrcB      aluSrcB;
        AluOp        aluOp;
        PcSrc        pcSrc;
        RegDstSel    regDstSel;
        WriteDataSel writeDataSel;
    } CtrlWord;

endpackage

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/100ps

module instrDecoder
    import ctrlPkg::*;
(
    input  logic [FieldW-1:0] opcode,
    input  logic [FieldW-1:0] funct,
    output OpKind             opKind
);

    always_comb begin
        opKind = opUnsupported;
        // funct picks the operation within R-type
        if (opcode == OpRType) begin
            case (funct)
                FunctAdd: begin
                    opKind = opAdd;
                end
                FunctSub: begin
                    opKind = opSub;
                end
                FunctAnd: begin
                    opKind = opAnd;
                end
                FunctSlt: begin
                    opKind = opSlt;
                end
                FunctJr: begin
                    opKind = opJumpReg;
                end
                FunctRte: begin
                    opKind = opExcReturn;
                end
                FunctBreak: begin
                    opKind = opBreak;
                end
                default: begin
                    opKind = opUnsupported;
                end
            endcase
        end
    end

endmodule

// ==== hdl/phaseSequencer.sv ====
`timescale 1ns/100ps

module phaseSequencer
    import ctrlPkg::*;
#(
    parameter int FetchWait = 3
) (
    input  logic             clk,
    input  logic             reset,
    input  OpKind            opKind,
    output Phase             phase,
    output logic [StepW-1:0] step,
    output OpKind            execOp,
    output logic             resetOut
);

    // index of the final execute step for the latched op
    logic [StepW-1:0] execLast;
    logic             lastStep;
    Phase             nextPhase;

    always_comb begin
        case (phase)
            phFetch: begin
                lastStep = (step == StepW'(FetchWait - 1));
            end
            phPcUpdate: begin
                lastStep = (step == StepW'(PcUpdateSteps - 1));
            end
            phDecode: begin
                lastStep = (step == StepW'(DecodeSteps - 1));
            end
            phExecute: begin
                lastStep = (step == execLast);
            end
            default: begin
                lastStep = 1'b1;
            end
        endcase
    end

    always_comb begin
        case (phase)
            phFetch: begin
                nextPhase = phPcUpdate;
            end
            phPcUpdate: begin
                nextPhase = phDecode;
            end
            phDecode: begin
                // unsupported ops have no execute phase
                nextPhase = (opKind == opUnsupported) ? phFetch : phExecute;
            end
            default: begin
                nextPhase = phFetch;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase    <= phReset;
            step     <= '0;
            resetOut <= 1'b1;
        end else begin
            resetOut <= 1'b0;
            if (lastStep) begin
                phase <= nextPhase;
                step  <= '0;
            end else begin
                step <= step + 1'b1;
            end
        end
    end

    // op sampled in the last decode cycle
    always_ff @(posedge clk) begin
        if (phase == phDecode && lastStep) begin
            execOp <= opKind;
            if (opKind == opExcReturn) begin
                execLast <= StepW'(ExecStepsRte - 1);
            end else begin
                execLast <= StepW'(ExecStepsFull - 1);
            end
        end
    end

endmodule

// ==== hdl/controlWordGen.sv ====
`timescale 1ns/100ps

module controlWordGen
    import ctrlPkg::*;
#(
    parameter int FetchWait = 3
) (
    input  Phase             phase,
    input  logic [StepW-1:0] step,
    input  OpKind            execOp,
    output CtrlWord          ctrl
);

    always_comb begin
        ctrl = '0;
        case (phase)
            phReset: begin
                ctrl.irWrite      = 1'b1;
                ctrl.regDstSel    = dstDefault;
                ctrl.writeDataSel = wdReset;
            end

            phFetch: begin
                // memory read while the ALU forms PC+4
                if (step < StepW'(FetchWait)) begin
                    ctrl.memRead   = 1'b1;
                    ctrl.aluSrcB   = srcBFour;
                    ctrl.aluOp     = aluAdd;
                    ctrl.regDstSel = dstDefault;
                end
            end

            phPcUpdate: begin
                ctrl.pcWrite   = 1'b1;
                ctrl.irWrite   = 1'b1;
                ctrl.regDstSel = dstDefault;
            end

            phDecode: begin
                if (step == StepW'(0)) begin
                    ctrl.aluSrcB   = srcBFour;
                    ctrl.aluOp     = aluAdd;
                    ctrl.regDstSel = dstDefault;
                end else if (step == StepW'(1)) begin
                    ctrl.aluOutWrite = 1'b1;
                    ctrl.regDstSel   = dstDefault;
                end
            end

            phExecute: begin
                case (execOp)
                    opAdd, opSub, opAnd, opSlt: begin
                        if (step == StepW'(0)) begin
                            ctrl.aluSrcA = srcARegA;
                            case (execOp)
                                opSub: begin
                                    ctrl.aluOp = aluSub;
                                end
                                opAnd: begin
                                    ctrl.aluOp = aluAnd;
                                end
                                opSlt: begin
                                    ctrl.aluOp = aluSlt;
                                end
                                default: begin
                                    ctrl.aluOp = aluAdd;
                                end
                            endcase
                        end else if (step == StepW'(1)) begin
                            // write back to rd
                            ctrl.regWrite     = 1'b1;
                            ctrl.regDstSel    = dstRd;
                            ctrl.writeDataSel = (execOp == opSlt) ? wdSltBit : wdAluWord;
                        end
                    end
                    opBreak: begin
                        // step back to the break address, then load PC
                        if (step == StepW'(0)) begin
                            ctrl.aluSrcB = srcBFour;
                            ctrl.aluOp   = aluSub;
                        end else if (step == StepW'(1)) begin
                            ctrl.pcWrite = 1'b1;
                            ctrl.pcSrc   = pcFromAlu;
                        end
                    end
                    opJumpReg: begin
                        if (step == StepW'(0)) begin
                            ctrl.aluSrcA = srcARegA;
                        end else if (step == StepW'(1)) begin
                            ctrl.pcWrite = 1'b1;
                            ctrl.pcSrc   = pcFromReg;
                        end
                    end
                    opExcReturn: begin
                        if (step == StepW'(0)) begin
                            ctrl.pcWrite = 1'b1;
                            ctrl.pcSrc   = pcFromReg;
                        end
                    end
                    default: begin
                        ctrl = '0;
                    end
                endcase
            end

            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

// ==== hdl/controlUnit.sv ====
`timescale 1ns/100ps

module controlUnit
    import ctrlPkg::*;
#(
    parameter int FetchWait = 3
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [FieldW-1:0] opcode,
    input  logic [FieldW-1:0] funct,
    output CtrlWord           ctrl,
    output logic              resetOut
);

    OpKind            opKind;
    OpKind            execOp;
    Phase             phase;
    logic [StepW-1:0] step;

    instrDecoder instrDecoder_i (
        .opcode (opcode),
        .funct  (funct),
        .opKind (opKind)
    );

    phaseSequencer #(
        .FetchWait (FetchWait)
    ) phaseSequencer_i (
        .clk      (clk),
        .reset    (reset),
        .opKind   (opKind),
        .phase    (phase),
        .step     (step),
        .execOp   (execOp),
        .resetOut (resetOut)
    );

    // word is combinational from the sequencer registers
    controlWordGen #(
        .FetchWait (FetchWait)
    ) controlWordGen_i (
        .phase  (phase),
        .step   (step),
        .execOp (execOp),
        .ctrl   (ctrl)
    );

endmodule

// ==== verif/ctrlModel.svh ====
`ifndef CTRL_MODEL_SVH
`define CTRL_MODEL_SVH

typedef struct packed {
    logic [FieldW-1:0] opcode;
    logic [FieldW-1:0] funct;
} Instr;

// funct selects the operation within R-type
function automatic OpKind decodeOp(Instr ins);
    OpKind k;
    k = opUnsupported;
    if (ins.opcode == 6'd0) begin
        case (ins.funct)
            6'd32: k = opAdd;
            6'd34: k = opSub;
            6'd36: k = opAnd;
            6'd42: k = opSlt;
            6'd8: k = opJumpReg;
            6'd19: k = opExcReturn;
            6'd13: k = opBreak;
            default: k = opUnsupported;
        endcase
    end
    return k;
endfunction

function automatic int execLength(OpKind op);
    if (op == opUnsupported) begin
        return 0;
    end else if (op == opExcReturn) begin
        return 1;
    end
    return 2;
endfunction

function automatic CtrlWord expectedWord(Phase ph, int st, OpKind op);
    CtrlWord w;
    w = '0;
    case (ph)
        phReset: begin
            w.irWrite = 1'b1;
            w.regDstSel = dstDefault;
            w.writeDataSel = wdReset;
        end
        phFetch: begin
            w.memRead = 1'b1;
            w.aluSrcB = srcBFour;
            w.aluOp = aluAdd;
            w.regDstSel = dstDefault;
        end
        phPcUpdate: begin
            w.pcWrite = 1'b1;
            w.irWrite = 1'b1;
            w.regDstSel = dstDefault;
        end
        phDecode: begin
            if (st == 0) begin
                w.aluSrcB = srcBFour;
                w.aluOp = aluAdd;
                w.regDstSel = dstDefault;
            end else if (st == 1) begin
                w.aluOutWrite = 1'b1;
                w.regDstSel = dstDefault;
            end
        end
        phExecute: begin
            if (op inside {opAdd, opSub, opAnd, opSlt}) begin
                if (st == 0) begin
                    w.aluSrcA = srcARegA;
                    w.aluOp = (op == opAdd) ? aluAdd :
                              (op == opSub) ? aluSub :
                              (op == opAnd) ? aluAnd : aluSlt;
                end else begin
                    w.regWrite = 1'b1;
                    w.regDstSel = dstRd;
                    w.writeDataSel = (op == opSlt) ? wdSltBit : wdAluWord;
                end
            end else if (op == opBreak) begin
                if (st == 0) begin
                    w.aluSrcB = srcBFour;
                    w.aluOp = aluSub;
                end else begin
                    w.pcWrite = 1'b1;
                    w.pcSrc = pcFromAlu;
                end
            end else if (op == opJumpReg && st == 0) begin
                w.aluSrcA = srcARegA;
            end else if (op == opJumpReg || op == opExcReturn) begin
                w.pcWrite = 1'b1;
                w.pcSrc = pcFromReg;
            end
        end
        default: begin
            w = '0;
        end
    endcase
    return w;
endfunction

task automatic checkWord(CtrlWord exp, CtrlWord got, string what);
    checkTotal++;
    if (got !== exp) begin
        errCount++;
        $display("** Error: %0t ns: %s mismatch, expected %h got %h", $time, what, exp, got);
    end
endtask

task automatic checkBit(logic exp, logic got, string what);
    checkTotal++;
    if (got !== exp) begin
        errCount++;
        $display("** Error: %0t ns: %s mismatch, expected %b got %b", $time, what, exp, got);
    end
endtask

task automatic checkCount(int exp, int got, string what);
    checkTotal++;
    if (got != exp) begin
        errCount++;
        $display("** Error: %0t ns: %s mismatch, expected %0d got %0d", $time, what, exp, got);
    end
endtask

`endif

// ==== verif/controlUnitTb.sv ====
`timescale 1ns/100ps

module controlUnitTb
    import ctrlPkg::*;
;

    localparam int FetchWait = 3;
    localparam int IrTimeout = 64;

    logic              clk;
    logic              reset;
    logic [FieldW-1:0] opcode;
    logic [FieldW-1:0] funct;
    CtrlWord           ctrl;
    logic              resetOut;

    int errCount = 0;
    int checkTotal = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int testErrStart = 0;

    `include "ctrlModel.svh"

    // model state follows the timing rules
    Phase  mPhase = phReset;
    int    mStep = 0;
    OpKind mOp = opUnsupported;
    logic  mResetOut = 1'b1;
    bit    checking = 0;

    Instr instrQ[$];
    logic [FieldW-1:0] goodFuncts[7] = '{6'd32, 6'd34, 6'd36, 6'd42, 6'd8, 6'd19, 6'd13};

    controlUnit controlUnit_i (
        .clk      (clk),
        .reset    (reset),
        .opcode   (opcode),
        .funct    (funct),
        .ctrl     (ctrl),
        .resetOut (resetOut)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            mPhase = phReset;
            mStep = 0;
            mResetOut = 1'b1;
        end else begin
            mResetOut = 1'b0;
            case (mPhase)
                phReset: begin
                    mPhase = phFetch;
                    mStep = 0;
                end
                phFetch: begin
                    if (mStep == FetchWait - 1) begin
                        mPhase = phPcUpdate;
                        mStep = 0;
                    end else begin
                        mStep++;
                    end
                end
                phPcUpdate: begin
                    mPhase = phDecode;
                    mStep = 0;
                end
                phDecode: begin
                    if (mStep == 2) begin
                        mOp = decodeOp('{opcode: opcode, funct: funct});
                        mPhase = (execLength(mOp) == 0) ? phFetch : phExecute;
                        mStep = 0;
                    end else begin
                        mStep++;
                    end
                end
                default: begin
                    if (mStep == execLength(mOp) - 1) begin
                        mPhase = phFetch;
                        mStep = 0;
                    end else begin
                        mStep++;
                    end
                end
            endcase
        end
        checking = 1;
    end

    // outputs are settled by mid-cycle
    always @(negedge clk) begin
        if (checking) begin
            checkWord(expectedWord(mPhase, mStep, mOp), ctrl, "ctrl");
            checkBit(mResetOut, resetOut, "resetOut");
        end
    end

    task automatic startTest();
        testErrStart = errCount;
        testsRun++;
    endtask

    task automatic finishTest(string name);
        int errs;
        errs = errCount - testErrStart;
        if (errs > 0) begin
            testsFailed++;
        end
        $display("test %-18s done, %0d errors", name, errs);
    endtask

    // irWrite outside reset marks the PC update cycle
    task automatic waitIrWrite(output int cycles);
        bit seen;
        seen = 0;
        cycles = 0;
        while (!seen && cycles < IrTimeout) begin
            @(negedge clk);
            cycles++;
            seen = ctrl.irWrite && !resetOut;
        end
        if (!seen) begin
            $display("timeout: no instruction load within %0d cycles at %0t ns",
                     IrTimeout, $time);
            $display("STATUS: FAIL");
            $finish;
        end
    endtask

    task automatic runList();
        int   cycles;
        Instr cur;
        while (instrQ.size() > 0) begin
            cur = instrQ.pop_front();
            @(posedge clk);
            #1;
            opcode = cur.opcode;
            funct = cur.funct;
            waitIrWrite(cycles);
            checkCount(FetchWait + 4 + execLength(decodeOp(cur)), cycles, "instruction length");
        end
    endtask

    function automatic Instr makeRandomInstr();
        Instr ins;
        int   r;
        r = int'($urandom % 10);
        if (r < 7) begin
            ins.opcode = 6'd0;
            ins.funct = goodFuncts[$urandom % 7];
        end else if (r < 9) begin
            ins.opcode = 6'd0;
            ins.funct = FieldW'($urandom % 64);
        end else begin
            ins.opcode = FieldW'(1 + $urandom % 63);
            ins.funct = FieldW'($urandom % 64);
        end
        return ins;
    endfunction

    initial begin
        int cycles;
        void'($urandom(18));
        reset = 1'b1;
        opcode = '0;
        funct = '0;

        startTest();
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        checkWord(expectedWord(phReset, 0, opUnsupported), ctrl, "ctrl after reset");
        checkBit(1'b1, resetOut, "resetOut after reset");
        @(negedge clk);
        checkWord(expectedWord(phFetch, 0, opUnsupported), ctrl, "first fetch");
        checkBit(1'b0, resetOut, "resetOut in fetch");
        waitIrWrite(cycles);
        finishTest("reset");

        startTest();
        instrQ = '{'{6'd0, 6'd32}, '{6'd0, 6'd36}};
        runList();
        finishTest("phase order");

        startTest();
        instrQ = '{'{6'd0, 6'd32}, '{6'd0, 6'd34}, '{6'd0, 6'd36}, '{6'd0, 6'd42}};
        runList();
        finishTest("alu ops");

        startTest();
        instrQ = '{'{6'd0, 6'd8}, '{6'd0, 6'd13}, '{6'd0, 6'd19}};
        runList();
        finishTest("pc writes");

        startTest();
        instrQ = '{'{6'd0, 6'd1}, '{6'd4, 6'd32}, '{6'd63, 6'd0}};
        repeat (200) begin
            instrQ.push_back(makeRandomInstr());
        end
        runList();
        finishTest("unsupported mix");

        startTest();
        @(posedge clk);
        #1;
        opcode = 6'd0;
        funct = 6'd34;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b1;
        repeat (2) @(negedge clk);
        checkWord(expectedWord(phReset, 0, opUnsupported), ctrl, "ctrl on mid reset");
        checkBit(1'b1, resetOut, "resetOut on mid reset");
        @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (2) @(negedge clk);
        checkWord(expectedWord(phFetch, 0, opUnsupported), ctrl, "fetch after mid reset");
        waitIrWrite(cycles);
        instrQ = '{'{6'd0, 6'd42}};
        runList();
        finishTest("mid reset");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 testsRun, testsFailed, checkTotal, errCount);
        if (errCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+verif
hdl/ctrlPkg.sv
hdl/instrDecoder.sv
hdl/phaseSequencer.sv
hdl/controlWordGen.sv
hdl/controlUnit.sv
verif/controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run with Verilator, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f vlog.f --top-module controlUnitTb -Mdir obj_dir -o simv &&
    ./obj_dir/simv | tee /dev/stderr | grep -q "^STATUS: PASS$" &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }
